//--- filelist.f
logic/wr_path_cfg_pkg.sv
logic/mem_req_pkg.sv
logic/req_fifo.sv
logic/burst_sequencer.sv
logic/dnn_wr_path.sv
sim/wr_path_checker.sv
sim/tb_dnn_wr_path.sv

//--- logic/burst_sequencer.sv
// one command at a time, one beat per cycle at most; a pu_id with no buffer stalls the command forever
`default_nettype none

module burst_sequencer
  import wr_path_cfg_pkg::*, mem_req_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_valid,    // macro queue not empty
  input  macro_cmd_t        cmd,          // macro queue head
  output logic              cmd_take,     // pops the macro queue
  input  logic [num_pu-1:0] outbuf_empty,
  input  pu_data_t          outbuf_data,
  output logic [num_pu-1:0] outbuf_pop,
  input  logic              req_q_full,
  output logic              beat_push,
  output mem_req_t          beat,
  output logic              busy,
  output logic              wr_done       // one cycle after the last beat
);

  seq_state_e state;
  seq_state_e state_next;

  // command being split, loaded on cmd_take
  logic [addr_w-1:0]  cur_addr;
  logic [size_w-1:0]  beats_left;
  logic [pu_id_w-1:0] pu_id;

  logic              sel_empty; // owning buffer status
  logic [data_w-1:0] sel_data;  // owning buffer head word
  logic              take;      // a beat moves this cycle
  logic              last_beat;
  logic              done_next;

  // pick the owning buffer
  always_comb begin
    sel_empty = 1'b1; // no match means nothing to drain
    sel_data  = '0;
    for (int p = 0; p < num_pu; p++) begin
      if (pu_id == pu_id_w'(p)) begin
        sel_empty = outbuf_empty[p];
        sel_data  = outbuf_data[p];
      end
    end
  end

  // a beat needs data on the buffer side and room in the output queue
  assign take = (state == active) && (beats_left != '0) && !sel_empty && !req_q_full;
  assign last_beat = (beats_left == size_w'(1));

  // zero beat commands finish after one active cycle
  assign done_next = (state == active) && ((beats_left == '0) || (take && last_beat));

  assign cmd_take = (state == idle) && cmd_valid; // same cycle accept
  assign busy = (state == active);
  assign beat_push = take;

  // pop only the owning buffer, together with the push
  always_comb begin
    for (int p = 0; p < num_pu; p++) begin
      outbuf_pop[p] = take && (pu_id == pu_id_w'(p));
    end
  end

  // request word, only meaningful with beat_push
  assign beat = '{
    op:   write,
    addr: mem_addr_w'(cur_addr), // zero extend to memory width
    data: sel_data,
    size: size_w'(beat_bytes)
  };

  always_comb begin
    state_next = state;
    case (state)
      idle:    if (cmd_valid) state_next = active;
      active:  if (done_next) state_next = idle;
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= idle;
      wr_done <= 1'b0;
    end else begin
      state   <= state_next;
      wr_done <= done_next; // registered pulse
    end
  end

  // address and count held under back-pressure
  always_ff @(posedge clk) begin
    if (cmd_take) begin
      cur_addr   <= cmd.addr;
      beats_left <= cmd.beats;
      pu_id      <= cmd.pu_id;
    end else if (take) begin
      cur_addr   <= cur_addr + addr_w'(beat_bytes);
      beats_left <= beats_left - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/dnn_wr_path.sv
// host raises wr_req only while wr_ready; req holds until granted; first req_valid comes 3+ cycles later
`default_nettype none

module dnn_wr_path
  import wr_path_cfg_pkg::*, mem_req_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              wr_req,       // one cycle strobe
  input  macro_cmd_t        wr_cmd,
  output logic              wr_ready,     // all queues drained, sequencer idle
  output logic              wr_done,
  input  logic [num_pu-1:0] outbuf_empty,
  input  pu_data_t          outbuf_data,
  output logic [num_pu-1:0] outbuf_pop,
  output logic              req_valid,
  output mem_req_t          req,
  input  logic              req_grant
);

  logic       macro_full;
  logic       macro_empty;
  macro_cmd_t cmd;       // macro queue head
  logic       cmd_take;
  logic       beat_push;
  mem_req_t   beat;
  logic       req_q_full;
  logic       req_q_empty;
  logic       busy;

  // host commands wait here until the sequencer is free
  req_fifo #(
    .width     ($bits(macro_cmd_t)),
    .log_depth (macro_q_log_depth)
  ) u_macro_q (
    .clk   (clk),
    .rst   (rst),
    .push  (wr_req && !macro_full),
    .din   (wr_cmd),
    .pop   (cmd_take),
    .dout  (cmd),
    .full  (macro_full),
    .empty (macro_empty)
  );

  burst_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (!macro_empty),
    .cmd          (cmd),
    .cmd_take     (cmd_take),
    .outbuf_empty (outbuf_empty),
    .outbuf_data  (outbuf_data),
    .outbuf_pop   (outbuf_pop),
    .req_q_full   (req_q_full),
    .beat_push    (beat_push),
    .beat         (beat),
    .busy         (busy),
    .wr_done      (wr_done)
  );

  // per-beat requests drain under valid/grant
  req_fifo #(
    .width     ($bits(mem_req_t)),
    .log_depth (req_q_log_depth)
  ) u_req_q (
    .clk   (clk),
    .rst   (rst),
    .push  (beat_push),
    .din   (beat),
    .pop   (req_valid && req_grant), // transfer on valid and grant
    .dout  (req),
    .full  (req_q_full),
    .empty (req_q_empty)
  );

  assign req_valid = !req_q_empty;
  assign wr_ready = macro_empty && req_q_empty && !busy; // drops the cycle after wr_req

endmodule

`default_nettype wire

//--- logic/mem_req_pkg.sv
// command and request formats; the memory side decodes op, addr, data and size in this bit order
`default_nettype none

package mem_req_pkg;

  import wr_path_cfg_pkg::*;

  // memory opcode, this path only ever issues write
  typedef enum logic {
    read  = 1'b0,
    write = 1'b1
  } mem_op_e;

  // host macro write command, also the macro queue entry
  typedef struct packed {
    logic [addr_w-1:0]  addr;  // byte address of first beat
    logic [size_w-1:0]  beats; // number of 8 byte beats, zero allowed
    logic [pu_id_w-1:0] pu_id; // owning PU, selects the output buffer
  } macro_cmd_t;

  // single beat memory request, also the output queue entry
  typedef struct packed {
    mem_op_e               op;
    logic [mem_addr_w-1:0] addr; // upper bits zero
    logic [data_w-1:0]     data;
    logic [size_w-1:0]     size; // bytes in this request
  } mem_req_t;

  // head words of all output buffers, index = PU id
  typedef logic [num_pu-1:0][data_w-1:0] pu_data_t;

  // sequencer FSM
  typedef enum logic {
    idle   = 1'b0,
    active = 1'b1
  } seq_state_e;

endpackage

`default_nettype wire

//--- logic/req_fifo.sv
// show-ahead queue; push while full and pop while empty are dropped, and dout is undefined when empty
`default_nettype none

module req_fifo #(
  parameter int width = 8,
  parameter int log_depth = 2
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [width-1:0] din,
  input  logic             pop,
  output logic [width-1:0] dout,
  output logic             full,
  output logic             empty
);

  logic [width-1:0] mem [1 << log_depth]; // storage, payload only

  logic [log_depth-1:0] wr_ptr; // wraps naturally at depth
  logic [log_depth-1:0] rd_ptr;
  logic [log_depth:0] count;      // one extra bit to hold depth itself
  logic [log_depth:0] count_next;
  logic do_push;
  logic do_pop;

  assign do_push = push && !full;  // guard against overrun
  assign do_pop = pop && !empty;   // and underrun
  assign dout = mem[rd_ptr];       // head visible without pop

  // occupancy after this edge
  always_comb begin
    case ({do_push, do_pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count; // idle, or push and pop together
    endcase
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
      full  <= count_next[log_depth]; // msb set only at count == depth
      empty <= (count_next == '0);
    end
  end

endmodule

`default_nettype wire

//--- logic/wr_path_cfg_pkg.sv
// sizing for a 2-PU write path; beat size is fixed at 8 bytes and queue depths must be powers of two
`default_nettype none

package wr_path_cfg_pkg;

  // processing units, one output buffer each
  localparam int num_pu = 2;
  localparam int pu_id_w = $clog2(num_pu) + 1; // one spare bit, as the host bus carries it

  // data and address widths
  localparam int data_w = 64;     // one beat of output buffer data
  localparam int addr_w = 32;     // host side byte address
  localparam int mem_addr_w = 64; // memory request address, zero extended

  // a beat moves this many bytes; address step and request size both use it
  localparam int beat_bytes = 8;

  localparam int size_w = 10; // beat count field, up to 1023 beats per command

  // queue depths as log2
  localparam int macro_q_log_depth = 2; // 4 pending host commands
  localparam int req_q_log_depth = 3;   // 8 requests waiting for grant

endpackage

`default_nettype wire

//--- sim/tb_dnn_wr_path.sv
// drives inputs on falling edges and samples 2 ns later; each row waits at most 500 cycles per phase
`default_nettype none

module tb_dnn_wr_path
  import wr_path_cfg_pkg::*, mem_req_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_cycles = 500;
  localparam int num_rows = 6;

  // one stimulus row: command plus traffic shaping
  typedef struct packed {
    logic [pu_id_w-1:0] pu;
    logic [addr_w-1:0]  addr;
    logic [size_w-1:0]  beats;
    int                 grant_pct; // chance of grant per cycle
    int                 stall_pct; // chance a buffer reads empty
    int                 hold;      // cycles with grant forced low
  } row_t;

  logic              clk = 1'b0;
  logic              rst;
  logic              wr_req;
  macro_cmd_t        wr_cmd;
  logic              wr_ready;
  logic              wr_done;
  logic [num_pu-1:0] outbuf_empty;
  pu_data_t          outbuf_data;
  logic [num_pu-1:0] outbuf_pop;
  logic              req_valid;
  mem_req_t          req;
  logic              req_grant;

  row_t              rows [num_rows];
  macro_cmd_t        next_cmd;          // goes out on wr_cmd at the next falling edge
  int                head_idx [num_pu]; // output buffer model counters
  logic [num_pu-1:0] pop_pending;       // pops seen this cycle, applied next falling edge
  mem_req_t          exp_q [$];         // scoreboard
  int                errors;
  int                rx_count;
  int                done_seen;
  int                grant_pct;
  int                stall_pct;
  int                hold_left;

  dnn_wr_path u_dut (
    .clk          (clk),
    .rst          (rst),
    .wr_req       (wr_req),
    .wr_cmd       (wr_cmd),
    .wr_ready     (wr_ready),
    .wr_done      (wr_done),
    .outbuf_empty (outbuf_empty),
    .outbuf_data  (outbuf_data),
    .outbuf_pop   (outbuf_pop),
    .req_valid    (req_valid),
    .req          (req),
    .req_grant    (req_grant)
  );

  bind dnn_wr_path wr_path_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .wr_req       (wr_req),
    .wr_ready     (wr_ready),
    .wr_done      (wr_done),
    .outbuf_empty (outbuf_empty),
    .outbuf_pop   (outbuf_pop),
    .req_valid    (req_valid),
    .req          (req),
    .req_grant    (req_grant)
  );

  always #10 clk = ~clk; // 20 ns period

  // PU tag in the top byte, word index below
  function automatic logic [data_w-1:0] make_word(input int p, input int k);
    return (data_w'(p) << (data_w - 8)) | data_w'(k);
  endfunction

  function automatic mem_req_t make_req(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    mem_req_t r;
    r.op   = write;
    r.addr = mem_addr_w'(a); // zero extended
    r.data = d;
    r.size = size_w'(beat_bytes);
    return r;
  endfunction

  task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout at %0t: %s", $time, why);
    $display("errors: %0d, timeouts: 1", errors);
    $display("TEST FAIL");
    $finish;
  endtask

  // one clock: drive on the falling edge, sample once things settle
  task automatic run_cycle(input logic strobe);
    @(negedge clk);
    for (int p = 0; p < num_pu; p++) begin
      if (pop_pending[p]) head_idx[p]++; // buffer drops its head
    end
    wr_req = strobe;
    wr_cmd = next_cmd;
    if (hold_left > 0) begin
      req_grant = 1'b0;
      hold_left--;
    end else begin
      req_grant = ($urandom_range(99) < grant_pct);
    end
    for (int p = 0; p < num_pu; p++) begin
      outbuf_empty[p] = ($urandom_range(99) < stall_pct);
      outbuf_data[p]  = make_word(p, head_idx[p]);
    end
    #2;
    pop_pending = outbuf_pop;
    if (wr_done) done_seen++;
    if (req_valid && req_grant) begin // transfer on the coming edge
      rx_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected request at %0t: %h", $time, req);
      end else begin
        check_req("req", exp_q.pop_front(), req);
      end
    end
  endtask

  task automatic wait_ready(input string what);
    int n;
    n = 0;
    while (wr_ready !== 1'b1) begin
      if (n == timeout_cycles) abort_run({"wr_ready never came back ", what});
      run_cycle(1'b0);
      n++;
    end
  endtask

  task automatic wait_done(input string what);
    int n;
    n = 0;
    while (done_seen == 0) begin
      if (n == timeout_cycles) abort_run({"no wr_done ", what});
      run_cycle(1'b0);
      n++;
    end
  endtask

  initial begin
    int other;
    int start_idx [num_pu];
    void'($urandom(32'h7902_837f));
    errors = 0;
    rst = 1'b1;
    wr_req = 1'b0;
    wr_cmd = '0;
    next_cmd = '0;
    outbuf_empty = '1;
    outbuf_data = '0;
    req_grant = 1'b0;
    pop_pending = '0;
    hold_left = 0;
    grant_pct = 100;
    stall_pct = 0;
    for (int p = 0; p < num_pu; p++) head_idx[p] = 0;

    // pu, addr, beats, grant %, stall %, hold
    rows[0] = '{1'b0, 32'h0000_1000, 10'd4, 100, 0, 0};
    rows[1] = '{1'b1, 32'h0000_2000, 10'd5, 100, 0, 0};
    rows[2] = '{1'b0, 32'h0000_3000, 10'd12, 30, 40, 0};
    rows[3] = '{1'b1, 32'h0000_4000, 10'd9, 30, 40, 0};
    rows[4] = '{1'b0, 32'h0000_5000, 10'd0, 100, 0, 0};
    rows[5] = '{1'b1, 32'h0000_6000, 10'd20, 80, 10, 40}; // overflows the output queue

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #2;
    check_bit("req_valid", 1'b0, req_valid);
    check_bit("wr_done", 1'b0, wr_done);
    check_bit("outbuf_pop[0]", 1'b0, outbuf_pop[0]);
    check_bit("outbuf_pop[1]", 1'b0, outbuf_pop[1]);
    check_bit("wr_ready", 1'b1, wr_ready);

    for (int r = 0; r < num_rows; r++) begin
      wait_ready("before command");
      grant_pct = rows[r].grant_pct;
      stall_pct = rows[r].stall_pct;
      hold_left = rows[r].hold;
      rx_count = 0;
      done_seen = 0;
      for (int p = 0; p < num_pu; p++) start_idx[p] = head_idx[p];
      // address steps by one beat, data follows the owning buffer
      for (int i = 0; i < int'(rows[r].beats); i++) begin
        exp_q.push_back(make_req(rows[r].addr + addr_w'(beat_bytes * i),
                                 make_word(rows[r].pu, start_idx[rows[r].pu] + i)));
      end
      next_cmd = '{addr: rows[r].addr, beats: rows[r].beats, pu_id: rows[r].pu};
      run_cycle(1'b1); // one cycle strobe
      wait_done("after command");
      wait_ready("after wr_done");
      other = 1 - int'(rows[r].pu);
      check_count("requests received", int'(rows[r].beats), rx_count);
      check_count("wr_done pulses", 1, done_seen);
      check_count("owning buffer pops", start_idx[rows[r].pu] + int'(rows[r].beats),
                  head_idx[rows[r].pu]);
      check_count("other buffer pops", start_idx[other], head_idx[other]);
      check_bit("req_valid", 1'b0, req_valid);
      exp_q.delete();
    end

    $display("errors: %0d, timeouts: 0", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/wr_path_checker.sv
// handshake assertions for dnn_wr_path; all checks are disabled while rst is high
`default_nettype none

module wr_path_checker
  import wr_path_cfg_pkg::*, mem_req_pkg::*;
(
  input logic              clk,
  input logic              rst,
  input logic              wr_req,
  input logic              wr_ready,
  input logic              wr_done,
  input logic [num_pu-1:0] outbuf_empty,
  input logic [num_pu-1:0] outbuf_pop,
  input logic              req_valid,
  input mem_req_t          req,
  input logic              req_grant
);

  timeunit 1ns;
  timeprecision 1ps;

  // request head must not move while it waits for grant
  req_hold_a: assert property (@(posedge clk) disable iff (rst)
    req_valid && !req_grant |=> $stable(req))
    else $error("req changed while waiting for grant");

  // at most one buffer popped, never an empty one
  pop_legal_a: assert property (@(posedge clk) disable iff (rst)
    $onehot0(outbuf_pop) && ((outbuf_pop & outbuf_empty) == '0))
    else $error("illegal outbuf_pop pattern");

  done_pulse_a: assert property (@(posedge clk) disable iff (rst)
    wr_done |=> !wr_done)
    else $error("wr_done high for two cycles");

  // host side rule
  req_ready_a: assert property (@(posedge clk) disable iff (rst)
    wr_req |-> wr_ready)
    else $error("wr_req raised while wr_ready low");

endmodule

`default_nettype wire
